//--- Bender.yml
package:
  name: slave_node

sources:
  - src/slave_pkg.sv
  - src/txn_if.sv
  - src/frame_decoder.sv
  - src/write_channel.sv
  - src/read_channel.sv
  - src/slave_node_top.sv
  - target: test
    files:
      - verif/link_model.sv
      - verif/tb_slave_node.sv

//--- sources.f
src/slave_pkg.sv
src/txn_if.sv
src/frame_decoder.sv
src/write_channel.sv
src/read_channel.sv
src/slave_node_top.sv
verif/link_model.sv
verif/tb_slave_node.sv

//--- src/frame_decoder.sv
`timescale 1ns/10ps

module frame_decoder import slave_pkg::*; #(
    parameter logic [ID_WIDTH-1:0] SLAVE_ID = '0
) (
    input  logic          clk,
    input  logic          rstN,
    input  logic          control,
    output logic          ready,
    txn_if.decoder        txn
);

    dec_state_t                 state;
    logic [FRAME_WIDTH-1:0]     frame_q;
    logic [FRAME_CNT_WIDTH-1:0] bit_cnt;
    logic                       active_write;
    logic                       frame_hit;
    logic                       channel_done;
    logic                       channel_ready;

    // frame from the msb down holds start code, slave id and r/w bit
    assign frame_hit = (frame_q[FRAME_WIDTH-1 -: START_WIDTH] == START_CODE) &&
                       (frame_q[ID_WIDTH:1] == SLAVE_ID);

    // launch pulses are decoded straight from the CHECK cycle
    assign txn.start_write = (state == CHECK) && frame_hit && frame_q[0];
    assign txn.start_read  = (state == CHECK) && frame_hit && !frame_q[0];

    assign channel_done  = active_write ? txn.write_done  : txn.read_done;
    assign channel_ready = active_write ? txn.write_ready : txn.read_ready;

    // master sees the channel's ready only while a transfer runs
    assign ready = (state != BUSY) || channel_ready;

    // control is shifted in until the frame is complete
    always_ff @(posedge clk) begin
        if (state == IDLE || state == FRAME) begin
            frame_q <= {frame_q[FRAME_WIDTH-2:0], control};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state        <= IDLE;
            bit_cnt      <= '0;
            active_write <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    // first high control bit opens a frame
                    if (control) begin
                        bit_cnt <= FRAME_CNT_WIDTH'(1);
                        state   <= FRAME;
                    end
                end
                FRAME: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == FRAME_CNT_WIDTH'(FRAME_WIDTH - 1)) begin
                        state <= CHECK;
                    end
                end
                CHECK: begin
                    if (frame_hit) begin
                        active_write <= frame_q[0];
                        state        <= BUSY;
                    end else begin
                        // not for this node
                        state <= IDLE;
                    end
                end
                BUSY: begin
                    if (channel_done) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

//--- src/read_channel.sv
`timescale 1ns/10ps

module read_channel import slave_pkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   g_tx_ready,
    input  logic   g_rx_done,
    input  word_t  g_rx_data,
    output logic   rD,
    output logic   g_tx_start,
    output word_t  g_tx_data,
    txn_if.reader  txn
);

    logic [STREAM_WIDTH-1:0]     out_shift;
    logic [STREAM_CNT_WIDTH-1:0] bit_cnt;
    logic                        rx_wait;
    logic                        ack_pending;

    // previous board always gets the ack byte
    assign g_tx_data  = word_t'(ACK_BYTE);
    assign g_tx_start = ack_pending && g_tx_ready;

    // line stays low outside the stream
    assign rD = txn.read_ready && out_shift[STREAM_WIDTH-1];

    // status nibble on top, read word below
    always_ff @(posedge clk) begin
        if (txn.start_read) begin
            out_shift[STREAM_WIDTH-1 -: STATUS_WIDTH] <= txn.write_status;
        end
        if (rx_wait && g_rx_done) begin
            out_shift[DATA_WIDTH-1:0] <= g_rx_data;
        end
        if (txn.read_ready) begin
            out_shift <= {out_shift[STREAM_WIDTH-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rx_wait        <= 1'b0;
            ack_pending    <= 1'b0;
            bit_cnt        <= '0;
            txn.read_ready <= 1'b0;
            txn.read_done  <= 1'b0;
        end else begin
            txn.read_done <= 1'b0;

            if (txn.start_read) begin
                rx_wait <= 1'b1;
            end

            // waits as long as the previous board needs
            if (rx_wait && g_rx_done) begin
                rx_wait     <= 1'b0;
                ack_pending <= 1'b1;
            end

            if (g_tx_start) begin
                ack_pending    <= 1'b0;
                txn.read_ready <= 1'b1;
                bit_cnt        <= '0;
            end

            if (txn.read_ready) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == STREAM_CNT_WIDTH'(STREAM_WIDTH - 1)) begin
                    txn.read_ready <= 1'b0;
                    txn.read_done  <= 1'b1;
                end
            end
        end
    end

endmodule

//--- src/slave_node_top.sv
`timescale 1ns/10ps

module slave_node_top import slave_pkg::*; #(
    parameter logic [ID_WIDTH-1:0] SLAVE_ID = '0
) (
    input  logic  clk,
    input  logic  rstN,

    // master side
    input  logic  control,
    input  logic  wD,
    input  logic  valid,
    output logic  rD,
    output logic  ready,

    // outgoing link towards the next board
    output logic  s_tx_start,
    output word_t s_tx_data,
    input  logic  s_tx_ready,
    input  logic  s_rx_done,
    input  word_t s_rx_data,

    // incoming link from the previous board
    output logic  g_tx_start,
    output word_t g_tx_data,
    input  logic  g_tx_ready,
    input  logic  g_rx_done,
    input  word_t g_rx_data
);

    txn_if txn (
        .clk (clk)
    );

    frame_decoder #(
        .SLAVE_ID (SLAVE_ID)
    ) frame_decoder_i (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .ready   (ready),
        .txn     (txn.decoder)
    );

    write_channel write_channel_i (
        .clk        (clk),
        .rstN       (rstN),
        .wD         (wD),
        .valid      (valid),
        .s_tx_ready (s_tx_ready),
        .s_rx_done  (s_rx_done),
        .s_rx_data  (s_rx_data),
        .s_tx_start (s_tx_start),
        .s_tx_data  (s_tx_data),
        .txn        (txn.writer)
    );

    read_channel read_channel_i (
        .clk        (clk),
        .rstN       (rstN),
        .g_tx_ready (g_tx_ready),
        .g_rx_done  (g_rx_done),
        .g_rx_data  (g_rx_data),
        .rD         (rD),
        .g_tx_start (g_tx_start),
        .g_tx_data  (g_tx_data),
        .txn        (txn.reader)
    );

endmodule

//--- src/slave_pkg.sv
package slave_pkg;

    // word and frame geometry
    localparam int DATA_WIDTH   = 32;
    localparam int ID_WIDTH     = 2;
    localparam int START_WIDTH  = 3;
    localparam int FRAME_WIDTH  = START_WIDTH + ID_WIDTH + 1;
    localparam int STATUS_WIDTH = 4;

    // status nibble followed by the read word
    localparam int STREAM_WIDTH = STATUS_WIDTH + DATA_WIDTH;

    localparam logic [START_WIDTH-1:0] START_CODE = 3'b111;

    // link acknowledge bytes whose upper nibble the master sees as status
    localparam logic [7:0] ACK_BYTE = 8'hCC;
    localparam logic [7:0] NAK_BYTE = 8'hAA;
    localparam logic [STATUS_WIDTH-1:0] ACK_STATUS = ACK_BYTE[7:4];
    localparam logic [STATUS_WIDTH-1:0] NAK_STATUS = NAK_BYTE[7:4];

    // acknowledge wait in cycles, then retransmissions before giving up
    localparam int ACK_TIMEOUT      = 64;
    localparam int RETRANSMIT_TIMES = 3;

    // counter widths
    localparam int FRAME_CNT_WIDTH  = $clog2(FRAME_WIDTH);
    localparam int WORD_CNT_WIDTH   = $clog2(DATA_WIDTH);
    localparam int STREAM_CNT_WIDTH = $clog2(STREAM_WIDTH);
    localparam int ACK_CNT_WIDTH    = $clog2(ACK_TIMEOUT);
    localparam int RETX_CNT_WIDTH   = $clog2(RETRANSMIT_TIMES + 1);

    typedef logic [DATA_WIDTH-1:0]   word_t;
    typedef logic [STATUS_WIDTH-1:0] status_t;

    typedef enum logic [1:0] {
        IDLE,
        FRAME,
        CHECK,
        BUSY
    } dec_state_t;

endpackage

//--- src/txn_if.sv
`timescale 1ns/10ps

interface txn_if import slave_pkg::*; (
    input logic clk
);

    // one-cycle launch pulses from the decoder
    logic    start_write;
    logic    start_read;

    // completion pulses and master ready requests from the channels
    logic    write_done;
    logic    read_done;
    logic    write_ready;
    logic    read_ready;

    // result of the last write, held until the next one finishes
    status_t write_status;

    modport decoder (
        input  clk,
        output start_write, start_read,
        input  write_done, read_done, write_ready, read_ready
    );

    modport writer (
        input  clk, start_write,
        output write_done, write_ready, write_status
    );

    modport reader (
        input  clk, start_read, write_status,
        output read_done, read_ready
    );

endinterface

//--- src/write_channel.sv
`timescale 1ns/10ps

module write_channel import slave_pkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   wD,
    input  logic   valid,
    input  logic   s_tx_ready,
    input  logic   s_rx_done,
    input  word_t  s_rx_data,
    output logic   s_tx_start,
    output word_t  s_tx_data,
    txn_if.writer  txn
);

    word_t                     wd_shift;
    logic [WORD_CNT_WIDTH-1:0] bit_cnt;
    logic                      tx_pending;
    logic                      ack_wait;
    logic [ACK_CNT_WIDTH-1:0]  ack_cnt;
    logic [RETX_CNT_WIDTH-1:0] retx_cnt;
    logic                      ack_timeout;
    logic                      retx_exhausted;

    // the deserializer doubles as the transmit word kept for retransmission
    assign s_tx_data = wd_shift;

    // start only in a cycle where the transmitter is ready
    assign s_tx_start = tx_pending && s_tx_ready;

    assign ack_timeout    = (ack_cnt == ACK_CNT_WIDTH'(ACK_TIMEOUT - 1));
    assign retx_exhausted = (retx_cnt == RETX_CNT_WIDTH'(RETRANSMIT_TIMES));

    // msb first, paused while valid is low
    always_ff @(posedge clk) begin
        if (txn.write_ready && valid) begin
            wd_shift <= {wd_shift[DATA_WIDTH-2:0], wD};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            txn.write_ready  <= 1'b0;
            txn.write_done   <= 1'b0;
            txn.write_status <= NAK_STATUS;
            bit_cnt          <= '0;
            tx_pending       <= 1'b0;
            ack_wait         <= 1'b0;
            ack_cnt          <= '0;
            retx_cnt         <= '0;
        end else begin
            txn.write_done <= 1'b0;

            if (txn.start_write) begin
                txn.write_ready <= 1'b1;
                bit_cnt         <= '0;
            end

            if (txn.write_ready && valid) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == WORD_CNT_WIDTH'(DATA_WIDTH - 1)) begin
                    txn.write_ready <= 1'b0;
                    tx_pending      <= 1'b1;
                    retx_cnt        <= '0;
                end
            end

            if (s_tx_start) begin
                tx_pending <= 1'b0;
                ack_wait   <= 1'b1;
                ack_cnt    <= '0;
            end

            if (ack_wait) begin
                if (s_rx_done) begin
                    ack_wait         <= 1'b0;
                    txn.write_done   <= 1'b1;
                    // anything other than the ack byte counts as failure
                    txn.write_status <= (s_rx_data == word_t'(ACK_BYTE)) ? ACK_STATUS
                                                                         : NAK_STATUS;
                end else if (ack_timeout) begin
                    ack_wait <= 1'b0;
                    if (retx_exhausted) begin
                        txn.write_status <= NAK_STATUS;
                        txn.write_done   <= 1'b1;
                    end else begin
                        // same word again
                        retx_cnt   <= retx_cnt + 1'b1;
                        tx_pending <= 1'b1;
                    end
                end else begin
                    ack_cnt <= ack_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- verif/link_model.sv
`timescale 1ns/10ps

module link_model import slave_pkg::*; (
    input  logic  clk,
    input  logic  silent,
    input  logic  wrong_byte,
    input  int    ack_delay,
    input  logic  s_tx_start,
    input  word_t s_tx_data,
    output logic  s_tx_ready,
    output logic  s_rx_done,
    output word_t s_rx_data,
    input  logic  g_req,
    input  word_t g_word,
    input  logic  g_tx_start,
    input  word_t g_tx_data,
    output logic  g_tx_ready,
    output logic  g_rx_done,
    output word_t g_rx_data
);

    localparam int LOG_DEPTH = 16;

    word_t s_tx_log [LOG_DEPTH];
    int    s_tx_cycle [LOG_DEPTH];
    int    s_tx_count;
    word_t g_tx_log [LOG_DEPTH];
    int    g_tx_count;
    int    cycle;
    int    reply_due;
    logic  reply_armed;
    int    g_delay;

    initial begin
        s_tx_count  = 0;
        g_tx_count  = 0;
        cycle       = 0;
        reply_due   = 0;
        reply_armed = 1'b0;
        g_delay     = 0;
        s_tx_ready  = 1'b1;
        s_rx_done   = 1'b0;
        s_rx_data   = '0;
        g_tx_ready  = 1'b1;
        g_rx_done   = 1'b0;
        g_rx_data   = '0;
    end

    // transmissions are logged where the DUT's outputs are stable
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (s_tx_start) begin
            if (s_tx_count < LOG_DEPTH) begin
                s_tx_log[s_tx_count]   = s_tx_data;
                s_tx_cycle[s_tx_count] = cycle;
            end
            s_tx_count = s_tx_count + 1;
            if (!silent) begin
                reply_armed = 1'b1;
                reply_due   = cycle + ack_delay;
            end
        end
        if (g_tx_start) begin
            if (g_tx_count < LOG_DEPTH) begin
                g_tx_log[g_tx_count] = g_tx_data;
            end
            g_tx_count = g_tx_count + 1;
        end
        // previous board answers a read request a few cycles later
        if (g_req) begin
            g_delay = 4;
        end
    end

    always @(negedge clk) begin
        s_rx_done <= 1'b0;
        g_rx_done <= 1'b0;
        // transmitters are busy now and then
        s_tx_ready <= (cycle % 3 != 0);
        g_tx_ready <= (cycle % 4 != 1);
        if (reply_armed && cycle >= reply_due) begin
            reply_armed = 1'b0;
            s_rx_done   <= 1'b1;
            s_rx_data   <= wrong_byte ? word_t'(NAK_BYTE) : word_t'(ACK_BYTE);
        end
        if (g_delay > 0) begin
            g_delay = g_delay - 1;
            if (g_delay == 0) begin
                g_rx_done <= 1'b1;
                g_rx_data <= g_word;
            end
        end
    end

endmodule

//--- verif/tb_slave_node.sv
`timescale 1ns/10ps

module tb_slave_node import slave_pkg::*; ();

    logic  clk = 1'b0;
    logic  rstN;
    logic  control;
    logic  wD;
    logic  valid;
    logic  rD;
    logic  ready;
    logic  s_tx_start;
    word_t s_tx_data;
    logic  s_tx_ready;
    logic  s_rx_done;
    word_t s_rx_data;
    logic  g_tx_start;
    word_t g_tx_data;
    logic  g_tx_ready;
    logic  g_rx_done;
    word_t g_rx_data;

    logic  silent;
    logic  wrong_byte;
    int    ack_delay;
    logic  g_req;
    word_t g_word;
    logic  ignore_window;
    int    errors;
    int    checks;

    always #10 clk = ~clk;

    slave_node_top #(
        .SLAVE_ID (2'd2)
    ) slave_node_top_i (
        .clk        (clk),
        .rstN       (rstN),
        .control    (control),
        .wD         (wD),
        .valid      (valid),
        .rD         (rD),
        .ready      (ready),
        .s_tx_start (s_tx_start),
        .s_tx_data  (s_tx_data),
        .s_tx_ready (s_tx_ready),
        .s_rx_done  (s_rx_done),
        .s_rx_data  (s_rx_data),
        .g_tx_start (g_tx_start),
        .g_tx_data  (g_tx_data),
        .g_tx_ready (g_tx_ready),
        .g_rx_done  (g_rx_done),
        .g_rx_data  (g_rx_data)
    );

    link_model link_model_i (
        .clk        (clk),
        .silent     (silent),
        .wrong_byte (wrong_byte),
        .ack_delay  (ack_delay),
        .s_tx_start (s_tx_start),
        .s_tx_data  (s_tx_data),
        .s_tx_ready (s_tx_ready),
        .s_rx_done  (s_rx_done),
        .s_rx_data  (s_rx_data),
        .g_req      (g_req),
        .g_word     (g_word),
        .g_tx_start (g_tx_start),
        .g_tx_data  (g_tx_data),
        .g_tx_ready (g_tx_ready),
        .g_rx_done  (g_rx_done),
        .g_rx_data  (g_rx_data)
    );

    assert property (@(posedge clk) disable iff (!rstN) s_tx_start |-> s_tx_ready)
        else begin
            errors++;
            $display("s_tx_start was raised while s_tx_ready was low");
        end

    assert property (@(posedge clk) disable iff (!rstN) g_tx_start |-> g_tx_data == 32'hCC)
        else begin
            errors++;
            $display("FAILED g_tx_data: expected cc, actual %0h", $sampled(g_tx_data));
        end

    // a frame for another id must leave the node alone
    assert property (@(posedge clk) ignore_window |-> ready && !s_tx_start && !g_tx_start)
        else begin
            errors++;
            $display("a frame for another slave id started a transfer or dropped ready");
        end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic wait_ready(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (ready !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        checks++;
        assert (ready === level) else begin
            errors++;
            $display("timed out waiting for ready to go %0b during %s", level, what);
        end
    endtask

    task automatic send_frame(input logic [1:0] id, input logic rw);
        logic [5:0] bits;
        bits = {3'b111, id, rw};
        for (int i = 5; i >= 0; i--) begin
            @(negedge clk);
            control = bits[i];
        end
        @(negedge clk);
        control = 1'b0;
    endtask

    task automatic send_word(input word_t word);
        for (int i = DATA_WIDTH - 1; i >= 0; i--) begin
            // random gaps in valid
            while ($urandom % 4 == 0) begin
                @(negedge clk);
                valid = 1'b0;
            end
            @(negedge clk);
            valid = 1'b1;
            wD    = word[i];
        end
        @(negedge clk);
        valid = 1'b0;
    endtask

    task automatic run_write(input word_t word, input logic no_answer, input logic bad_ack);
        silent     = no_answer;
        wrong_byte = bad_ack;
        ack_delay  = 1 + $urandom % 30;
        send_frame(2'd2, 1'b1);
        send_word(word);
        wait_ready(1'b0, 5, "write transmit");
        wait_ready(1'b1, 1000, "write acknowledge");
    endtask

    task automatic run_read(input word_t word, output logic [STREAM_WIDTH-1:0] bits);
        g_word = word;
        send_frame(2'd2, 1'b0);
        @(negedge clk);
        g_req = 1'b1;
        @(negedge clk);
        g_req = 1'b0;
        wait_ready(1'b0, 5, "read start");
        wait_ready(1'b1, 100, "read acknowledge");
        for (int i = STREAM_WIDTH - 1; i >= 0; i--) begin
            assert (ready === 1'b1) else begin
                errors++;
                $display("ready dropped during the read stream at bit %0d", i);
            end
            bits[i] = rD;
            @(negedge clk);
        end
        wait_ready(1'b1, 5, "read done");
    endtask

    task automatic check_read(input string name, input logic [3:0] status);
        word_t                   gw;
        int                      gbase;
        logic [STREAM_WIDTH-1:0] stream;
        gw    = $urandom;
        gbase = link_model_i.g_tx_count;
        run_read(gw, stream);
        check_value({name, " stream"}, {status, gw}, stream);
        check_value({name, " g_tx count"}, 1, link_model_i.g_tx_count - gbase);
        check_value({name, " g_tx data"}, 32'hCC, link_model_i.g_tx_log[gbase]);
    endtask

    initial begin
        word_t w;
        int    base;
        int    gbase;
        void'($urandom(32'hd051c64e));
        errors        = 0;
        checks        = 0;
        rstN          = 1'b0;
        control       = 1'b0;
        wD            = 1'b0;
        valid         = 1'b0;
        silent        = 1'b0;
        wrong_byte    = 1'b0;
        ack_delay     = 1;
        g_req         = 1'b0;
        g_word        = '0;
        ignore_window = 1'b0;
        repeat (3) @(negedge clk);
        rstN = 1'b1;
        check_value("reset ready", 1, ready);
        check_value("reset rD", 0, rD);

        // write answered by the next board
        w    = $urandom;
        base = link_model_i.s_tx_count;
        run_write(w, 1'b0, 1'b0);
        check_value("ack write count", 1, link_model_i.s_tx_count - base);
        check_value("ack write data", w, link_model_i.s_tx_log[base]);

        // silent link so every retransmission carries the same word
        w    = $urandom;
        base = link_model_i.s_tx_count;
        run_write(w, 1'b1, 1'b0);
        check_value("retransmit count", RETRANSMIT_TIMES + 1, link_model_i.s_tx_count - base);
        for (int i = 0; i <= RETRANSMIT_TIMES; i++) begin
            check_value("retransmit data", w, link_model_i.s_tx_log[base + i]);
            if (i > 0) begin
                checks++;
                assert (link_model_i.s_tx_cycle[base + i] -
                        link_model_i.s_tx_cycle[base + i - 1] >= ACK_TIMEOUT) else begin
                    errors++;
                    $display("retransmission %0d came before the acknowledge timeout", i);
                end
            end
        end
        check_value("ready after retransmit", 1, ready);
        check_read("read after silent write", 4'hA);

        run_write($urandom, 1'b0, 1'b0);
        check_read("read after good write", 4'hC);

        run_write($urandom, 1'b0, 1'b1);
        check_read("read after wrong byte", 4'hA);

        // frames for id 1 with a word behind the write frame
        base          = link_model_i.s_tx_count;
        gbase         = link_model_i.g_tx_count;
        ignore_window = 1'b1;
        send_frame(2'd1, 1'b1);
        send_word($urandom);
        send_frame(2'd1, 1'b0);
        repeat (10) @(negedge clk);
        ignore_window = 1'b0;
        check_value("other id s_tx count", 0, link_model_i.s_tx_count - base);
        check_value("other id g_tx count", 0, link_model_i.g_tx_count - gbase);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
